// ==== Makefile ====
TOP = bpu_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f bpu.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f bpu.f --top-module $(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bpu.f ====
logic/bpu_pkg.sv
logic/bpu_update_if.sv
logic/bpu_lfsr.sv
logic/bpu_dir_table.sv
logic/bpu_target_buffer.sv
logic/bpu_next_pc.sv
logic/bpu_top.sv
tb/bpu_chk.sv
tb/bpu_tb.sv

// ==== logic/bpu_dir_table.sv ====
`timescale 1ns/1ns

module bpu_dir_table (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [bpu_pkg::XLEN-1:0] pc_i,
  input  logic                     is_branch_i,
  bpu_update_if.sink               upd,
  output logic                     dir_hit_o,
  output logic                     dir_taken_o
);

  logic [bpu_pkg::BHT_NUM-1:0] ent_valid;
  logic [bpu_pkg::XLEN-1:0]    ent_pc  [bpu_pkg::BHT_NUM];
  logic [bpu_pkg::CNT_W-1:0]   ent_cnt [bpu_pkg::BHT_NUM];

  logic                          rd_hit;
  logic                          rd_upper;
  logic                          wr_hit;
  logic [bpu_pkg::BHT_IDX_W-1:0] wr_hit_idx;
  logic [bpu_pkg::BHT_IDX_W-1:0] victim_idx;
  logic [bpu_pkg::BHT_IDX_W-1:0] wr_idx;
  logic                          upd_en;
  logic                          alloc;
  logic [bpu_pkg::CNT_W-1:0]     cur_cnt;
  logic [bpu_pkg::CNT_W-1:0]     nxt_cnt;

  // lookup against all valid entries
  always_comb begin
    rd_hit   = 1'b0;
    rd_upper = 1'b0;
    for (int i = 0; i < bpu_pkg::BHT_NUM; i++) begin
      if (ent_valid[i] && ent_pc[i] == pc_i) begin
        rd_hit   = 1'b1;
        rd_upper = ent_cnt[i][bpu_pkg::CNT_W-1];
      end
    end
  end

  assign dir_hit_o   = is_branch_i & rd_hit;
  assign dir_taken_o = dir_hit_o & rd_upper;

  // update side match
  always_comb begin
    wr_hit     = 1'b0;
    wr_hit_idx = '0;
    for (int i = 0; i < bpu_pkg::BHT_NUM; i++) begin
      if (ent_valid[i] && ent_pc[i] == upd.pc) begin
        wr_hit     = 1'b1;
        wr_hit_idx = i[bpu_pkg::BHT_IDX_W-1:0];
      end
    end
  end

  assign upd_en  = upd.valid & upd.is_branch;
  assign alloc   = upd_en & ~wr_hit;
  assign wr_idx  = wr_hit ? wr_hit_idx : victim_idx;
  assign cur_cnt = ent_cnt[wr_idx];

  bpu_lfsr #(
    .DEPTH(bpu_pkg::BHT_NUM)
  ) u_lfsr (
    .clk    (clk),
    .rst    (rst),
    .alloc_i(alloc),
    .idx_o  (victim_idx)
  );

  // new entries start weak, existing ones saturate at 0 and 3
  always_comb begin
    nxt_cnt = cur_cnt;
    if (!wr_hit) begin
      nxt_cnt = upd.taken ? bpu_pkg::CNT_WEAK_T : bpu_pkg::CNT_WEAK_N;
    end else if (upd.taken && cur_cnt != '1) begin
      nxt_cnt = cur_cnt + 1'b1;
    end else if (!upd.taken && cur_cnt != '0) begin
      nxt_cnt = cur_cnt - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ent_valid <= '0;
    end else if (upd_en) begin
      ent_valid[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (upd_en) begin
      ent_pc[wr_idx]  <= upd.pc;
      ent_cnt[wr_idx] <= nxt_cnt;
    end
  end

endmodule

// ==== logic/bpu_lfsr.sv ====
`timescale 1ns/1ns

module bpu_lfsr #(
  parameter int DEPTH = 16
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     alloc_i,
  output logic [$clog2(DEPTH)-1:0] idx_o
);

  logic [7:0] state;
  logic       feedback;

  // taps 8,6,5,4
  assign feedback = state[7] ^ state[5] ^ state[4] ^ state[3];

  // step only when a victim was consumed
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= 8'h01;
    end else if (alloc_i) begin
      state <= {state[6:0], feedback};
    end
  end

  // victim entry for the next allocation
  assign idx_o = state[$clog2(DEPTH)-1:0];

endmodule

// ==== logic/bpu_next_pc.sv ====
`timescale 1ns/1ns

module bpu_next_pc (
  input  logic [bpu_pkg::XLEN-1:0] pc_i,
  input  logic                     dir_hit_i,
  input  logic                     dir_taken_i,
  input  logic                     tgt_hit_i,
  input  logic [bpu_pkg::XLEN-1:0] tgt_addr_i,
  output logic                     hit_o,
  output logic                     taken_o,
  output logic [bpu_pkg::XLEN-1:0] next_pc_o
);

  logic [bpu_pkg::XLEN-1:0] fall_through;

  assign fall_through = pc_i + bpu_pkg::INSN_BYTES;

  // redirect needs both a taken prediction and a known target
  assign taken_o = dir_taken_i & tgt_hit_i;

  assign hit_o = dir_hit_i;

  // otherwise keep fetching sequentially
  assign next_pc_o = taken_o ? tgt_addr_i : fall_through;

endmodule

// ==== logic/bpu_pkg.sv ====
package bpu_pkg;

  // pc and target width
  localparam int XLEN = 32;

  // table sizes
  localparam int BHT_NUM = 16;
  localparam int BTB_NUM = 8;

  // index widths of the two tables
  localparam int BHT_IDX_W = $clog2(BHT_NUM);
  localparam int BTB_IDX_W = $clog2(BTB_NUM);

  // 2-bit saturating counter
  // 3 strong taken, 2 weak taken, 1 weak not taken, 0 strong not taken
  localparam int CNT_W = 2;
  localparam logic [CNT_W-1:0] CNT_WEAK_T = 2'd2;
  localparam logic [CNT_W-1:0] CNT_WEAK_N = 2'd1;

  // fall-through step for 32-bit instructions
  localparam logic [XLEN-1:0] INSN_BYTES = 32'd4;

endpackage

// ==== logic/bpu_target_buffer.sv ====
`timescale 1ns/1ns

module bpu_target_buffer (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [bpu_pkg::XLEN-1:0] pc_i,
  bpu_update_if.sink               upd,
  output logic                     tgt_hit_o,
  output logic [bpu_pkg::XLEN-1:0] tgt_addr_o
);

  logic [bpu_pkg::BTB_NUM-1:0] ent_valid;
  logic [bpu_pkg::XLEN-1:0]    ent_pc  [bpu_pkg::BTB_NUM];
  logic [bpu_pkg::XLEN-1:0]    ent_tgt [bpu_pkg::BTB_NUM];

  logic                          rd_hit;
  logic [bpu_pkg::XLEN-1:0]      rd_tgt;
  logic                          wr_hit;
  logic [bpu_pkg::BTB_IDX_W-1:0] wr_hit_idx;
  logic [bpu_pkg::BTB_IDX_W-1:0] victim_idx;
  logic [bpu_pkg::BTB_IDX_W-1:0] wr_idx;
  logic                          wr_en;
  logic                          alloc;

  // lookup, independent of the branch marker
  always_comb begin
    rd_hit = 1'b0;
    rd_tgt = '0;
    for (int i = 0; i < bpu_pkg::BTB_NUM; i++) begin
      if (ent_valid[i] && ent_pc[i] == pc_i) begin
        rd_hit = 1'b1;
        rd_tgt = ent_tgt[i];
      end
    end
  end

  assign tgt_hit_o  = rd_hit;
  assign tgt_addr_o = rd_tgt;

  // match for the update pc
  always_comb begin
    wr_hit     = 1'b0;
    wr_hit_idx = '0;
    for (int i = 0; i < bpu_pkg::BTB_NUM; i++) begin
      if (ent_valid[i] && ent_pc[i] == upd.pc) begin
        wr_hit     = 1'b1;
        wr_hit_idx = i[bpu_pkg::BTB_IDX_W-1:0];
      end
    end
  end

  // only taken branches carry a useful target
  assign wr_en  = upd.valid & upd.is_branch & upd.taken;
  assign alloc  = wr_en & ~wr_hit;
  assign wr_idx = wr_hit ? wr_hit_idx : victim_idx;

  bpu_lfsr #(
    .DEPTH(bpu_pkg::BTB_NUM)
  ) u_lfsr (
    .clk    (clk),
    .rst    (rst),
    .alloc_i(alloc),
    .idx_o  (victim_idx)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      ent_valid <= '0;
    end else if (wr_en) begin
      ent_valid[wr_idx] <= 1'b1;
    end
  end

  // a hit overwrites the old target in place
  always_ff @(posedge clk) begin
    if (wr_en) begin
      ent_pc[wr_idx]  <= upd.pc;
      ent_tgt[wr_idx] <= upd.target;
    end
  end

endmodule

// ==== logic/bpu_top.sv ====
`timescale 1ns/1ns

module bpu_top (
  input  logic                     clk,
  input  logic                     rst,
  // fetch lookup
  input  logic [bpu_pkg::XLEN-1:0] pc_i,
  input  logic                     is_branch_i,
  output logic                     hit_o,
  output logic                     taken_o,
  output logic [bpu_pkg::XLEN-1:0] next_pc_o,
  // execute resolution
  input  logic                     upd_valid_i,
  input  logic [bpu_pkg::XLEN-1:0] upd_pc_i,
  input  logic                     upd_branch_i,
  input  logic                     upd_taken_i,
  input  logic [bpu_pkg::XLEN-1:0] upd_target_i
);

  logic                     dir_hit;
  logic                     dir_taken;
  logic                     tgt_hit;
  logic [bpu_pkg::XLEN-1:0] tgt_addr;

  bpu_update_if upd_bus ();

  // producer view of the update bus
  assign upd_bus.valid     = upd_valid_i;
  assign upd_bus.pc        = upd_pc_i;
  assign upd_bus.is_branch = upd_branch_i;
  assign upd_bus.taken     = upd_taken_i;
  assign upd_bus.target    = upd_target_i;

  bpu_dir_table u_dir_table (
    .clk        (clk),
    .rst        (rst),
    .pc_i       (pc_i),
    .is_branch_i(is_branch_i),
    .upd        (upd_bus.sink),
    .dir_hit_o  (dir_hit),
    .dir_taken_o(dir_taken)
  );

  bpu_target_buffer u_target_buffer (
    .clk       (clk),
    .rst       (rst),
    .pc_i      (pc_i),
    .upd       (upd_bus.sink),
    .tgt_hit_o (tgt_hit),
    .tgt_addr_o(tgt_addr)
  );

  bpu_next_pc u_next_pc (
    .pc_i       (pc_i),
    .dir_hit_i  (dir_hit),
    .dir_taken_i(dir_taken),
    .tgt_hit_i  (tgt_hit),
    .tgt_addr_i (tgt_addr),
    .hit_o      (hit_o),
    .taken_o    (taken_o),
    .next_pc_o  (next_pc_o)
  );

endmodule

// ==== logic/bpu_update_if.sv ====
`timescale 1ns/1ns

// one branch resolution coming back from execute
interface bpu_update_if;

  logic                     valid;
  logic [bpu_pkg::XLEN-1:0] pc;
  logic                     is_branch;
  logic                     taken;
  logic [bpu_pkg::XLEN-1:0] target;

  // execute side
  modport src (
    output valid,
    output pc,
    output is_branch,
    output taken,
    output target
  );

  // predictor tables
  modport sink (
    input valid,
    input pc,
    input is_branch,
    input taken,
    input target
  );

endinterface

// ==== tb/bpu_chk.sv ====
`timescale 1ns/1ns

module bpu_chk (
  input logic                     clk,
  input logic                     rst,
  input logic [bpu_pkg::XLEN-1:0] pc_i,
  input logic                     hit_i,
  input logic                     taken_i,
  input logic [bpu_pkg::XLEN-1:0] next_pc_i
);

  int fails = 0;

  // a redirect needs a direction hit
  taken_needs_hit: assert property (@(posedge clk) disable iff (rst) taken_i |-> hit_i)
    else begin
      fails++;
      $error("taken_o is high while hit_o is low");
    end

  // no redirect means sequential fetch
  fall_through_pc: assert property (@(posedge clk) disable iff (rst)
    !taken_i |-> next_pc_i == pc_i + bpu_pkg::INSN_BYTES)
    else begin
      fails++;
      $error("next_pc_o is not pc_i+4 while taken_o is low");
    end

endmodule

bind bpu_top bpu_chk bpu_chk_i (
  .clk      (clk),
  .rst      (rst),
  .pc_i     (pc_i),
  .hit_i    (hit_o),
  .taken_i  (taken_o),
  .next_pc_i(next_pc_o)
);

// ==== tb/bpu_tb.sv ====
`timescale 1ns/1ns

module bpu_tb;

  logic                     clk;
  logic                     rst;
  logic [bpu_pkg::XLEN-1:0] pc_i;
  logic                     is_branch_i;
  logic                     hit_o;
  logic                     taken_o;
  logic [bpu_pkg::XLEN-1:0] next_pc_o;
  logic                     upd_valid_i;
  logic [bpu_pkg::XLEN-1:0] upd_pc_i;
  logic                     upd_branch_i;
  logic                     upd_taken_i;
  logic [bpu_pkg::XLEN-1:0] upd_target_i;

  // one row is {upd_valid, upd_pc, upd_branch, upd_taken, upd_target, pc, is_branch}
  logic [3*bpu_pkg::XLEN+3:0] stim      [$];
  logic [1:0]                 exp_flags [$];
  logic [bpu_pkg::XLEN-1:0]   exp_next  [$];
  string                      names     [$];
  logic [bpu_pkg::XLEN-1:0]   rng;
  int                         errors;
  int                         checks;

  bpu_top bpu_top_i (.*);

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // flags are {upd_valid, upd_branch, upd_taken, is_branch, expected hit, expected taken}
  task automatic add_step(input string name, input logic [5:0] f,
                          input logic [bpu_pkg::XLEN-1:0] upc,
                          input logic [bpu_pkg::XLEN-1:0] tgt,
                          input logic [bpu_pkg::XLEN-1:0] lpc,
                          input logic [bpu_pkg::XLEN-1:0] nxt);
    stim.push_back({f[5], upc, f[4], f[3], tgt, lpc, f[2]});
    exp_flags.push_back(f[1:0]);
    exp_next.push_back(nxt);
    names.push_back(name);
  endtask

  task automatic check_value(input string name, input string field,
                             input logic [bpu_pkg::XLEN-1:0] expected,
                             input logic [bpu_pkg::XLEN-1:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("FAILED %s %s expected %0h actual %0h", name, field, expected, actual);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  initial begin
    logic [bpu_pkg::XLEN-1:0] p [5];
    logic [bpu_pkg::XLEN-1:0] t [5];
    rst = 1'b1;
    {upd_valid_i, upd_pc_i, upd_branch_i, upd_taken_i, upd_target_i, pc_i, is_branch_i} = '0;
    errors = 0;
    checks = 0;
    rng = 32'hba73_8e85;
    // index in the low pc bits keeps the pcs distinct
    for (int i = 0; i < 5; i++) begin
      rng = lcg_next(rng);
      p[i] = {rng[31:6], i[3:0], 2'b00};
      rng = lcg_next(rng);
      t[i] = {rng[31:2], 2'b00};
    end
    add_step("reset_miss",       6'b000100, p[0], t[0], p[0], p[0] + 4);
    add_step("alloc_taken",      6'b111111, p[0], t[0], p[0], t[0]);
    // p[1] counter runs 2, 3, 3, 2, 1, 0
    add_step("sat_taken_1",      6'b111111, p[1], t[1], p[1], t[1]);
    add_step("sat_taken_2",      6'b111111, p[1], t[1], p[1], t[1]);
    add_step("sat_taken_3",      6'b111111, p[1], t[1], p[1], t[1]);
    add_step("sat_not_taken_1",  6'b110111, p[1], t[2], p[1], t[1]);
    add_step("sat_not_taken_2",  6'b110110, p[1], t[2], p[1], p[1] + 4);
    add_step("sat_not_taken_3",  6'b110110, p[1], t[2], p[1], p[1] + 4);
    add_step("alloc_not_taken",  6'b110110, p[2], t[2], p[2], p[2] + 4);
    add_step("lookup_no_branch", 6'b000000, p[0], t[3], p[0], p[0] + 4);
    add_step("update_no_branch", 6'b101111, p[0], t[3], p[0], t[0]);
    // p[0] counter still weakly taken, so one not-taken drops it to 1
    add_step("no_branch_kept",   6'b110110, p[0], t[3], p[0], p[0] + 4);
    add_step("update_not_valid", 6'b011100, p[3], t[3], p[3], p[3] + 4);
    add_step("retarget",         6'b111111, p[0], t[4], p[0], t[4]);
    repeat (8) @(negedge clk);
    rst = 1'b0;
    foreach (stim[k]) begin
      @(negedge clk);
      {upd_valid_i, upd_pc_i, upd_branch_i, upd_taken_i, upd_target_i, pc_i, is_branch_i} =
        stim[k];
      // update is written at the coming rising edge
      @(negedge clk);
      upd_valid_i = 1'b0;
      #1;
      check_value(names[k], "hit_o", 32'(exp_flags[k][1]), 32'(hit_o));
      check_value(names[k], "taken_o", 32'(exp_flags[k][0]), 32'(taken_o));
      check_value(names[k], "next_pc_o", exp_next[k], next_pc_o);
    end
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
             bpu_top_i.bpu_chk_i.fails);
    if (errors == 0 && bpu_top_i.bpu_chk_i.fails == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // reset plus eight cycles per step
  initial begin
    #1;
    repeat (8 + stim.size() * 8) @(posedge clk);
    $display("timeout: the step table did not finish within its cycle budget");
    $display("STATUS: FAIL");
    $finish;
  end

endmodule
